// ==== sdhc_cmd_pkg.sv ====
// ==================================================
// SD host command path package
// Frame sizes, queue and timeout constants, CRC7
// ==================================================
package sdhc_cmd_pkg;

  localparam int unsigned CMD_FRAME_W = 48;
  localparam int unsigned CMD_INDEX_W = 6;
  localparam int unsigned CMD_ARG_W   = 32;
  localparam int unsigned CLK_DIV_W   = 8;
  localparam int unsigned FIFO_DEPTH  = 4;
  localparam int unsigned FIFO_PTR_W  = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned RSP_TIMEOUT = 64;  // SD clock periods
  localparam int unsigned NCR_MIN     = 2;

  typedef logic [CMD_FRAME_W-1:0] cmd_frame_t;

  typedef struct packed {
    logic [CMD_INDEX_W-1:0] index;
    logic [CMD_ARG_W-1:0]   arg;
    logic                   crc_error;
    logic                   end_bit_error;
    logic                   index_error;
    logic                   timeout;
    logic                   no_response;
  } sd_rsp_t;

  // One serial step of x^7 + x^3 + 1
  function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic data);
    logic fb;
    fb = crc[6] ^ data;
    return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
  endfunction

endpackage

// ==== sd_clk_divider.sv ====
// ==================================================
// SD clock divider
// SD clock and its edge enable pulses
// ==================================================
module sd_clk_divider (
  input  logic                                clk_i,
  input  logic                                software_reset_cmd_q,
  input  logic [sdhc_cmd_pkg::CLK_DIV_W-1:0]  clk_div_i,
  output logic                                sd_clk_o,
  output logic                                clk_en_p_o,
  output logic                                clk_en_n_o
);
  import sdhc_cmd_pkg::*;

  logic [CLK_DIV_W-1:0] div_cnt_q;
  logic                 sd_clk_q;
  logic                 toggle;

  // Half period is clk_div_i + 1 system cycles
  assign toggle = (div_cnt_q >= clk_div_i);

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      div_cnt_q <= '0;
      sd_clk_q  <= 1'b0;
    end else if (toggle) begin
      div_cnt_q <= '0;
      sd_clk_q  <= ~sd_clk_q;
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  // Pulses flag the edge on which sd_clk_o changes,
  // so registers enabled by them move with the SD clock
  assign clk_en_p_o = toggle & ~sd_clk_q;
  assign clk_en_n_o = toggle & sd_clk_q;
  assign sd_clk_o   = sd_clk_q;

endmodule

// ==== cmd_frame_builder.sv ====
// ==================================================
// Command frame builder
// Host command into a 48-bit frame with CRC7
// ==================================================
module cmd_frame_builder (
  input  logic                                  clk_i,
  input  logic                                  software_reset_cmd_q,
  input  logic                                  cmd_valid_i,
  input  logic [sdhc_cmd_pkg::CMD_INDEX_W-1:0]  cmd_index_i,
  input  logic [sdhc_cmd_pkg::CMD_ARG_W-1:0]    cmd_arg_i,
  output logic                                  frame_push_o,
  output sdhc_cmd_pkg::cmd_frame_t              frame_o
);
  import sdhc_cmd_pkg::*;

  logic [CMD_FRAME_W-9:0] head;  // start, transmission, index, argument
  logic [6:0]             crc;

  always_comb begin
    head = {1'b0, 1'b1, cmd_index_i, cmd_arg_i};
    crc  = '0;
    for (int i = CMD_FRAME_W - 9; i >= 0; i--) begin
      crc = crc7_next(crc, head[i]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      frame_push_o <= 1'b0;
    end else begin
      frame_push_o <= cmd_valid_i;
    end
  end

  // Frame data only matters with the push strobe
  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      frame_o <= {head, crc, 1'b1};
    end
  end

endmodule

// ==== frame_fifo.sv ====
// ==================================================
// Frame FIFO
// Circular buffer, payload type set per instance
// ==================================================
module frame_fifo #(
  parameter type payload_t = sdhc_cmd_pkg::cmd_frame_t
) (
  input  logic     clk_i,
  input  logic     software_reset_cmd_q,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);
  import sdhc_cmd_pkg::*;

  payload_t              mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic                  do_push;
  logic                  do_pop;

  assign do_push = push_i & ~full_o;  // Dropped when full
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));

endmodule

// ==== cmd_line_engine.sv ====
// ==================================================
// CMD line engine
// Sends frames on CMD, receives and checks responses
// ==================================================
module cmd_line_engine (
  input  logic                      clk_i,
  input  logic                      software_reset_cmd_q,
  input  logic                      clk_en_p_i,
  input  logic                      clk_en_n_i,
  input  sdhc_cmd_pkg::cmd_frame_t  frame_i,
  input  logic                      frame_empty_i,
  input  logic                      rsp_full_i,
  input  logic                      sd_cmd_i,
  output logic                      frame_pop_o,
  output logic                      sd_cmd_o,
  output logic                      sd_cmd_oe_o,
  output logic                      rsp_push_o,
  output sdhc_cmd_pkg::sd_rsp_t     rsp_o,
  output logic                      busy_o
);
  import sdhc_cmd_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_send,
    st_wait_rsp,
    st_recv,
    st_report
  } state_e;

  state_e                                   state_q;
  cmd_frame_t                               shift_q;
  logic [$clog2(CMD_FRAME_W+1)-1:0]         bit_cnt_q;
  logic [$clog2(NCR_MIN+RSP_TIMEOUT+1)-1:0] wait_cnt_q;
  logic [CMD_INDEX_W-1:0]                   cmd_index_q;
  logic [6:0]                               crc_q;
  logic                                     timeout_q;
  logic                                     no_rsp_q;
  logic                                     start;
  logic                                     got_rsp;

  // Full response queue holds off the next command
  assign start       = (state_q == st_idle) && !frame_empty_i && !rsp_full_i;
  assign frame_pop_o = start;
  assign rsp_push_o  = (state_q == st_report);
  assign busy_o      = (state_q != st_idle);

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      state_q     <= st_idle;
      bit_cnt_q   <= '0;
      wait_cnt_q  <= '0;
      sd_cmd_o    <= 1'b1;
      sd_cmd_oe_o <= 1'b0;
      timeout_q   <= 1'b0;
      no_rsp_q    <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (start) begin
            shift_q     <= frame_i;
            cmd_index_q <= frame_i[45:40];
            bit_cnt_q   <= '0;
            timeout_q   <= 1'b0;
            no_rsp_q    <= 1'b0;
            state_q     <= st_send;
          end
        end
        st_send: begin
          if (clk_en_n_i) begin
            if (bit_cnt_q == CMD_FRAME_W) begin  // End bit done, release CMD
              sd_cmd_oe_o <= 1'b0;
              sd_cmd_o    <= 1'b1;
              wait_cnt_q  <= '0;
              if (cmd_index_q == '0) begin
                no_rsp_q <= 1'b1;
                state_q  <= st_report;
              end else begin
                state_q <= st_wait_rsp;
              end
            end else begin
              sd_cmd_oe_o <= 1'b1;
              sd_cmd_o    <= shift_q[CMD_FRAME_W-1];
              shift_q     <= {shift_q[CMD_FRAME_W-2:0], 1'b1};
              bit_cnt_q   <= bit_cnt_q + 1'b1;
            end
          end
        end
        st_wait_rsp: begin
          if (clk_en_p_i) begin
            if (wait_cnt_q >= NCR_MIN && !sd_cmd_i) begin  // Start bit
              shift_q   <= {shift_q[CMD_FRAME_W-2:0], 1'b0};
              crc_q     <= '0;
              bit_cnt_q <= 1;
              state_q   <= st_recv;
            end else if (wait_cnt_q == NCR_MIN + RSP_TIMEOUT - 1) begin
              timeout_q <= 1'b1;
              state_q   <= st_report;
            end else begin
              wait_cnt_q <= wait_cnt_q + 1'b1;
            end
          end
        end
        st_recv: begin
          if (clk_en_p_i) begin
            shift_q   <= {shift_q[CMD_FRAME_W-2:0], sd_cmd_i};
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q < CMD_FRAME_W - 8) crc_q <= crc7_next(crc_q, sd_cmd_i);
            if (bit_cnt_q == CMD_FRAME_W - 1) state_q <= st_report;
          end
        end
        st_report: state_q <= st_idle;  // One push cycle
        default:   state_q <= st_idle;
      endcase
    end
  end

  assign got_rsp = !timeout_q && !no_rsp_q;

  always_comb begin
    rsp_o               = '0;
    rsp_o.index         = shift_q[45:40];
    rsp_o.arg           = shift_q[39:8];
    rsp_o.crc_error     = got_rsp && (shift_q[7:1] != crc_q);
    rsp_o.end_bit_error = got_rsp && !shift_q[0];
    rsp_o.index_error   = got_rsp && (shift_q[45:40] != cmd_index_q);
    rsp_o.timeout       = timeout_q;
    rsp_o.no_response   = no_rsp_q;
  end

endmodule

// ==== sdhc_cmd_path.sv ====
// ==================================================
// SD host command path top level
// Divider, frame builder, two queues, CMD engine
// ==================================================
module sdhc_cmd_path (
  input  logic                                  clk_i,
  input  logic                                  software_reset_cmd_q,
  input  logic                                  cmd_valid_i,
  input  logic [sdhc_cmd_pkg::CMD_INDEX_W-1:0]  cmd_index_i,
  input  logic [sdhc_cmd_pkg::CMD_ARG_W-1:0]    cmd_arg_i,
  output logic                                  cmd_full_o,
  output logic                                  rsp_valid_o,
  output logic [sdhc_cmd_pkg::CMD_INDEX_W-1:0]  rsp_index_o,
  output logic [sdhc_cmd_pkg::CMD_ARG_W-1:0]    rsp_arg_o,
  output logic                                  rsp_crc_error_o,
  output logic                                  rsp_end_bit_error_o,
  output logic                                  rsp_index_error_o,
  output logic                                  rsp_timeout_o,
  output logic                                  rsp_no_response_o,
  input  logic                                  rsp_pop_i,
  input  logic [sdhc_cmd_pkg::CLK_DIV_W-1:0]    clk_div_i,
  output logic                                  sd_clk_o,
  output logic                                  sd_cmd_o,
  output logic                                  sd_cmd_oe_o,
  input  logic                                  sd_cmd_i,
  output logic                                  cmd_inhibit_o
);
  import sdhc_cmd_pkg::*;

  logic       clk_en_p, clk_en_n;
  logic       frame_push, frame_pop, frame_empty;
  cmd_frame_t frame_in, frame_out;
  logic       rsp_push, rsp_full, rsp_empty;
  sd_rsp_t    rsp_in, rsp_out;

  sd_clk_divider clk_divider (
    .clk_i,
    .software_reset_cmd_q,
    .clk_div_i,
    .sd_clk_o,
    .clk_en_p_o (clk_en_p),
    .clk_en_n_o (clk_en_n)
  );

  cmd_frame_builder frame_builder (
    .clk_i,
    .software_reset_cmd_q,
    .cmd_valid_i,
    .cmd_index_i,
    .cmd_arg_i,
    .frame_push_o (frame_push),
    .frame_o      (frame_in)
  );

  frame_fifo #(.payload_t(cmd_frame_t)) cmd_queue (
    .clk_i,
    .software_reset_cmd_q,
    .push_i  (frame_push),
    .data_i  (frame_in),
    .pop_i   (frame_pop),
    .data_o  (frame_out),
    .empty_o (frame_empty),
    .full_o  (cmd_full_o)
  );

  cmd_line_engine line_engine (
    .clk_i,
    .software_reset_cmd_q,
    .clk_en_p_i    (clk_en_p),
    .clk_en_n_i    (clk_en_n),
    .frame_i       (frame_out),
    .frame_empty_i (frame_empty),
    .rsp_full_i    (rsp_full),
    .sd_cmd_i,
    .frame_pop_o   (frame_pop),
    .sd_cmd_o,
    .sd_cmd_oe_o,
    .rsp_push_o    (rsp_push),
    .rsp_o         (rsp_in),
    .busy_o        (cmd_inhibit_o)
  );

  frame_fifo #(.payload_t(sd_rsp_t)) rsp_queue (
    .clk_i,
    .software_reset_cmd_q,
    .push_i  (rsp_push),
    .data_i  (rsp_in),
    .pop_i   (rsp_pop_i),
    .data_o  (rsp_out),
    .empty_o (rsp_empty),
    .full_o  (rsp_full)
  );

  assign rsp_valid_o         = ~rsp_empty;
  assign rsp_index_o         = rsp_out.index;
  assign rsp_arg_o           = rsp_out.arg;
  assign rsp_crc_error_o     = rsp_out.crc_error;
  assign rsp_end_bit_error_o = rsp_out.end_bit_error;
  assign rsp_index_error_o   = rsp_out.index_error;
  assign rsp_timeout_o       = rsp_out.timeout;
  assign rsp_no_response_o   = rsp_out.no_response;

endmodule

// ==== tb_clock_gen.sv ====
// ==================================================
// Testbench clock source
// ==================================================
module tb_clock_gen #(
  parameter int unsigned PERIOD = 10
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

// ==== sdhc_cmd_assertions.sv ====
// ==================================================
// CMD line engine assertions
// Bound into every cmd_line_engine instance
// ==================================================
module sdhc_cmd_assertions (
  input logic clk_i,
  input logic software_reset_cmd_q,
  input logic clk_en_n_i,
  input logic sd_cmd_oe_o,
  input logic frame_pop_o,
  input logic rsp_push_o,
  input logic rsp_full_i
);

  logic in_flight_q;  // Popped command still waiting for its response push

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      in_flight_q <= 1'b0;
    end else if (frame_pop_o) begin
      in_flight_q <= 1'b1;
    end else if (rsp_push_o) begin
      in_flight_q <= 1'b0;
    end
  end

  // Output enable moves only with the SD clock falling edge
  oe_on_falling_edge: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    $changed(sd_cmd_oe_o) |-> $past(clk_en_n_i))
    else $error("sd_cmd_oe_o changed without clk_en_n");

  pop_only_when_idle: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    frame_pop_o |-> !in_flight_q)
    else $error("command frame popped while engine busy");

  push_only_when_room: assert property (@(posedge clk_i) disable iff (software_reset_cmd_q)
    rsp_push_o |-> !rsp_full_i)
    else $error("response pushed into a full response FIFO");

endmodule

bind cmd_line_engine sdhc_cmd_assertions engine_checks (.*);

// ==== tb_sdhc_cmd_path.sv ====
// ==================================================
// SD host command path testbench
// Card model, command table, response checks
// ==================================================
module tb_sdhc_cmd_path;
  import sdhc_cmd_pkg::*;

  localparam int unsigned DIV        = 1;
  localparam int unsigned SD_CLK_T   = 2 * (DIV + 1) * 10;
  localparam int unsigned CMD_CYCLES = 2 * (DIV + 1) * (CMD_FRAME_W + RSP_TIMEOUT + 60);
  localparam int unsigned ROWS       = 10;
  localparam int unsigned BP_CMDS    = FIFO_DEPTH + 1;
  localparam longint      WATCHDOG_T = (ROWS + BP_CMDS + 4) * CMD_CYCLES * 10 + 2000;
  localparam int CARD_OK      = 0;
  localparam int CARD_BAD_CRC = 1;
  localparam int CARD_END0    = 2;
  localparam int CARD_BAD_IDX = 3;
  localparam int CARD_SILENT  = 4;

  logic                   clk;
  logic                   software_reset_cmd_q;
  logic                   cmd_valid;
  logic [CMD_INDEX_W-1:0] cmd_index;
  logic [CMD_ARG_W-1:0]   cmd_arg;
  logic                   cmd_full;
  logic                   rsp_valid;
  logic [CMD_INDEX_W-1:0] rsp_index;
  logic [CMD_ARG_W-1:0]   rsp_arg;
  logic                   rsp_crc_err;
  logic                   rsp_end_err;
  logic                   rsp_idx_err;
  logic                   rsp_timeout;
  logic                   rsp_no_rsp;
  logic                   rsp_pop;
  logic [CLK_DIV_W-1:0]   clk_div;
  logic                   sd_clk;
  logic                   sd_cmd;
  logic                   sd_cmd_oe;
  logic                   sd_cmd_in;
  logic                   cmd_inhibit;

  logic [CMD_INDEX_W-1:0] tbl_index [ROWS];
  logic [CMD_ARG_W-1:0]   tbl_arg   [ROWS];
  int                     tbl_card  [ROWS];
  logic [4:0]             tbl_flags [ROWS];  // crc, end bit, index, timeout, no response
  cmd_frame_t             exp_frames [$];
  int                     card_mode   = CARD_OK;
  int                     frames_seen = 0;
  int                     checks      = 0;
  int                     errors      = 0;

  tb_clock_gen #(.PERIOD(10)) clock_gen (.clk_o(clk));

  sdhc_cmd_path dut0 (
    .clk_i               (clk),
    .software_reset_cmd_q(software_reset_cmd_q),
    .cmd_valid_i         (cmd_valid),
    .cmd_index_i         (cmd_index),
    .cmd_arg_i           (cmd_arg),
    .cmd_full_o          (cmd_full),
    .rsp_valid_o         (rsp_valid),
    .rsp_index_o         (rsp_index),
    .rsp_arg_o           (rsp_arg),
    .rsp_crc_error_o     (rsp_crc_err),
    .rsp_end_bit_error_o (rsp_end_err),
    .rsp_index_error_o   (rsp_idx_err),
    .rsp_timeout_o       (rsp_timeout),
    .rsp_no_response_o   (rsp_no_rsp),
    .rsp_pop_i           (rsp_pop),
    .clk_div_i           (clk_div),
    .sd_clk_o            (sd_clk),
    .sd_cmd_o            (sd_cmd),
    .sd_cmd_oe_o         (sd_cmd_oe),
    .sd_cmd_i            (sd_cmd_in),
    .cmd_inhibit_o       (cmd_inhibit)
  );

  // CRC7 by polynomial division, message times x^7 mod x^7+x^3+1
  function automatic logic [6:0] crc7_div(input logic [39:0] msg);
    logic [46:0] rem;
    rem = {msg, 7'b0};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i]) rem[i -: 8] = rem[i -: 8] ^ 8'h89;
    end
    return rem[6:0];
  endfunction

  function automatic cmd_frame_t expected_frame(input logic [5:0] idx, input logic [31:0] arg);
    logic [39:0] body;
    body = {2'b01, idx, arg};
    return {body, crc7_div(body), 1'b1};
  endfunction

  function automatic logic [31:0] reply_arg(input logic [31:0] arg);
    return ~arg;  // Card status derived from the command argument
  endfunction

  function automatic cmd_frame_t make_reply(input logic [5:0] idx, input logic [31:0] arg,
                                            input int mode);
    logic [5:0]  sent_idx;
    logic [39:0] body;
    logic [6:0]  crc;
    sent_idx = (mode == CARD_BAD_IDX) ? idx ^ 6'h01 : idx;
    body     = {2'b00, sent_idx, reply_arg(arg)};
    crc      = crc7_div(body);
    if (mode == CARD_BAD_CRC) crc = crc ^ 7'h01;
    return {body, crc, (mode != CARD_END0)};
  endfunction

  task automatic check_val(input string name, input logic [47:0] got, input logic [47:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic set_row(input int r, input logic [5:0] idx, input logic [31:0] arg,
                         input int card, input logic [4:0] flags);
    tbl_index[r] = idx;
    tbl_arg[r]   = arg;
    tbl_card[r]  = card;
    tbl_flags[r] = flags;
  endtask

  task automatic check_idle_outputs();
    check_val("sd_cmd_oe_o", sd_cmd_oe, 0);
    check_val("rsp_valid_o", rsp_valid, 0);
    check_val("cmd_full_o", cmd_full, 0);
    check_val("cmd_inhibit_o", cmd_inhibit, 0);
    check_val("sd_cmd_o", sd_cmd, 1);
  endtask

  task automatic issue_cmd(input logic [5:0] idx, input logic [31:0] arg);
    while (cmd_full) begin
      @(posedge clk);
      #1;
    end
    exp_frames.push_back(expected_frame(idx, arg));
    cmd_valid = 1'b1;
    cmd_index = idx;
    cmd_arg   = arg;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic pop_and_check(input logic [5:0] idx, input logic [31:0] arg, input int mode,
                               input logic [4:0] flags);
    int n;
    n = 0;
    while (!rsp_valid && n < CMD_CYCLES) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!rsp_valid) begin
      report_error($sformatf("no response for CMD%0d within %0d cycles", idx, CMD_CYCLES));
      return;
    end
    check_val("rsp error flags {crc,end,index,timeout,no_rsp}",
              {rsp_crc_err, rsp_end_err, rsp_idx_err, rsp_timeout, rsp_no_rsp}, flags);
    if (flags[1:0] == 2'b00) begin
      check_val("rsp_index_o", rsp_index, (mode == CARD_BAD_IDX) ? idx ^ 6'h01 : idx);
      check_val("rsp_arg_o", rsp_arg, reply_arg(arg));
    end
    rsp_pop = 1'b1;
    @(posedge clk);
    #1;
    rsp_pop = 1'b0;
  endtask

  task automatic wait_frames(input int target);
    int n;
    n = 0;
    while (frames_seen < target && n < BP_CMDS * CMD_CYCLES) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (frames_seen < target) report_error("card did not see the queued commands on CMD");
  endtask

  // Card side: sample on SD clock rise, drive on SD clock fall
  task automatic capture_frame(output cmd_frame_t f);
    time last_edge;
    f = '0;
    do @(posedge sd_clk); while (!sd_cmd_oe);
    f = {f[CMD_FRAME_W-2:0], sd_cmd};
    repeat (CMD_FRAME_W - 1) begin
      last_edge = $time;
      @(posedge sd_clk);
      check_val("sd_clk_o period", $time - last_edge, SD_CLK_T);
      f = {f[CMD_FRAME_W-2:0], sd_cmd};
    end
  endtask

  task automatic send_reply(input cmd_frame_t rsp);
    repeat (3) @(negedge sd_clk);
    for (int i = CMD_FRAME_W - 1; i >= 0; i--) begin
      if (i != CMD_FRAME_W - 1) @(negedge sd_clk);
      #1;
      sd_cmd_in = rsp[i];
    end
    @(negedge sd_clk);
    #1;
    sd_cmd_in = 1'b1;  // Pull-up
  endtask

  initial begin : card_model
    cmd_frame_t frame;
    cmd_frame_t exp;
    sd_cmd_in = 1'b1;
    forever begin
      capture_frame(frame);
      frames_seen++;
      if (exp_frames.size() == 0) begin
        report_error("card saw a command frame that was never issued");
      end else begin
        exp = exp_frames.pop_front();
        check_val("command frame on sd_cmd_o", frame, exp);
      end
      if (frame[45:40] != '0 && card_mode != CARD_SILENT) begin
        send_reply(make_reply(frame[45:40], frame[39:8], card_mode));
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_T);
    $display("Watchdog expired at %0t before the tests completed", $time);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : main
    int                     base;
    logic [CMD_INDEX_W-1:0] bp_index [BP_CMDS];
    logic [CMD_ARG_W-1:0]   bp_arg   [BP_CMDS];
    logic                   oe_seen;
    void'($urandom(25108));
    software_reset_cmd_q = 1'b1;
    cmd_valid = 1'b0;
    cmd_index = '0;
    cmd_arg   = '0;
    rsp_pop   = 1'b0;
    clk_div   = CLK_DIV_W'(DIV);

    set_row(0, 6'd0,  32'h0000_0000, CARD_OK,      5'b00001);
    set_row(1, 6'd8,  32'h0000_01AA, CARD_OK,      5'b00000);
    set_row(2, 6'd55, $urandom(),    CARD_OK,      5'b00000);
    set_row(3, 6'd41, $urandom(),    CARD_OK,      5'b00000);
    set_row(4, 6'd2,  $urandom(),    CARD_BAD_CRC, 5'b10000);
    set_row(5, 6'd3,  $urandom(),    CARD_END0,    5'b01000);
    set_row(6, 6'd7,  $urandom(),    CARD_BAD_IDX, 5'b00100);
    set_row(7, 6'd9,  $urandom(),    CARD_SILENT,  5'b00010);
    set_row(8, 6'd13, $urandom(),    CARD_OK,      5'b00000);
    set_row(9, 6'd0,  $urandom(),    CARD_SILENT,  5'b00001);

    repeat (3) @(posedge clk);
    #1;
    check_idle_outputs();
    repeat (7) @(posedge clk);
    #1;
    software_reset_cmd_q = 1'b0;
    check_idle_outputs();

    for (int i = 0; i < ROWS; i++) begin
      card_mode = tbl_card[i];
      issue_cmd(tbl_index[i], tbl_arg[i]);
      pop_and_check(tbl_index[i], tbl_arg[i], tbl_card[i], tbl_flags[i]);
    end

    // Queue more commands than the response FIFO holds
    card_mode = CARD_OK;
    base      = frames_seen;
    for (int i = 0; i < BP_CMDS; i++) begin
      bp_index[i] = CMD_INDEX_W'(16 + i);
      bp_arg[i]   = $urandom();
      issue_cmd(bp_index[i], bp_arg[i]);
    end
    wait_frames(base + FIFO_DEPTH);
    check_val("cmd_inhibit_o while a command is held", cmd_inhibit, 1);
    while (cmd_inhibit) begin
      @(posedge clk);
      #1;
    end
    oe_seen = 1'b0;
    repeat (CMD_CYCLES) begin
      @(posedge clk);
      #1;
      oe_seen = oe_seen | sd_cmd_oe;
    end
    check_val("sd_cmd_oe_o while response FIFO full", oe_seen, 0);
    check_val("frames on CMD while response FIFO full", frames_seen, base + FIFO_DEPTH);
    for (int i = 0; i < BP_CMDS; i++) begin
      pop_and_check(bp_index[i], bp_arg[i], CARD_OK, 5'b00000);
    end
    check_val("frames on CMD after the stall", frames_seen, base + BP_CMDS);
    check_val("issued frames missing on CMD", exp_frames.size(), 0);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
sdhc_cmd_pkg.sv
sd_clk_divider.sv
cmd_frame_builder.sv
frame_fifo.sv
cmd_line_engine.sv
sdhc_cmd_path.sv
tb_clock_gen.sv
sdhc_cmd_assertions.sv
tb_sdhc_cmd_path.sv

// ==== Bender.yml ====
package:
  name: sdhc_cmd_path

sources:
  - sdhc_cmd_pkg.sv
  - sd_clk_divider.sv
  - cmd_frame_builder.sv
  - frame_fifo.sv
  - cmd_line_engine.sv
  - sdhc_cmd_path.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - sdhc_cmd_assertions.sv
      - tb_sdhc_cmd_path.sv
